// ==== verilog/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath geometry
`define XLEN      32
`define REG_NUM   32
`define REG_AW    5
`define ZERO_REG  5'd0      // x0, hardwired zero
`define SHAMT_W   5         // shift amount bits taken from rs2
`define IMM_W     20        // upper immediate for lui
`define ALU_OP_W  3

// debug port fields
`define DBG_CMD_W    1
`define DBG_STATE_W  2

`endif

// ==== verilog/rv_alu_pkg.sv ====
`default_nettype none

`include "core_consts.svh"

package rv_alu_pkg;

    // one architectural register value
    typedef logic [`XLEN-1:0] word_t;

    // register index, x0..x31
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,     // shifts use rs2[4:0]
        ALU_SRL = 3'd6,
        ALU_LUI = 3'd7      // imm << 12, sources ignored
    } alu_op_e;

endpackage

`default_nettype wire

// ==== verilog/dbg_pkg.sv ====
`default_nettype none

`include "core_consts.svh"

package dbg_pkg;

    typedef enum logic [`DBG_CMD_W-1:0] {
        DBG_READ  = 1'b0,
        DBG_WRITE = 1'b1
    } dbg_cmd_e;

    // four-phase slave sequencing
    typedef enum logic [`DBG_STATE_W-1:0] {
        DBG_IDLE     = 2'd0,
        DBG_WAIT_GNT = 2'd1,    // access in progress, writes wait for the port
        DBG_ACK      = 2'd2,
        DBG_RELEASE  = 2'd3
    } dbg_state_e;

endpackage

`default_nettype wire

// ==== verilog/gpr_port_if.sv ====
`default_nettype none

// one agent's view of the register file
interface gpr_port_if;

    logic                  we;
    rv_alu_pkg::reg_addr_t waddr;
    rv_alu_pkg::word_t     wdata;
    rv_alu_pkg::reg_addr_t raddr1;
    rv_alu_pkg::reg_addr_t raddr2;
    rv_alu_pkg::word_t     rdata1;
    rv_alu_pkg::word_t     rdata2;
    logic                  gnt;     // write port granted this cycle

    modport agent (
        output we, waddr, wdata, raddr1, raddr2,
        input  rdata1, rdata2, gnt
    );

    modport rf (
        input  we, waddr, wdata, raddr1, raddr2,
        output rdata1, rdata2, gnt
    );

endinterface

`default_nettype wire

// ==== verilog/gpr_file.sv ====
`default_nettype none

`include "core_consts.svh"

module gpr_file (
    input  logic    clk,
    input  logic    rst_n_i,
    gpr_port_if.rf  ex_port,
    gpr_port_if.rf  dbg_port
);

    rv_alu_pkg::word_t regs [0:`REG_NUM-1];
    logic              dbg_gnt;

    // execute read with same-cycle forwarding from the execute write
    function automatic rv_alu_pkg::word_t bypass_read(
        input rv_alu_pkg::reg_addr_t ra,
        input rv_alu_pkg::word_t     mem_val,
        input logic                  we,
        input rv_alu_pkg::reg_addr_t wa,
        input rv_alu_pkg::word_t     wd
    );
        rv_alu_pkg::word_t val;
        if (ra == `ZERO_REG) begin
            val = '0;
        end else if (we && (ra == wa)) begin
            val = wd;
        end else begin
            val = mem_val;
        end
        return val;
    endfunction

    // execute never waits, debug gets whatever cycles execute leaves free
    assign dbg_gnt      = ~ex_port.we;
    assign ex_port.gnt  = 1'b1;
    assign dbg_port.gnt = dbg_gnt;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ex_port.we && (ex_port.waddr != `ZERO_REG)) begin
                regs[ex_port.waddr] <= ex_port.wdata;
            end else if (dbg_port.we && dbg_gnt && (dbg_port.waddr != `ZERO_REG)) begin
                regs[dbg_port.waddr] <= dbg_port.wdata;
            end
        end
    end

    assign ex_port.rdata1 = bypass_read(ex_port.raddr1, regs[ex_port.raddr1],
                                        ex_port.we, ex_port.waddr, ex_port.wdata);
    assign ex_port.rdata2 = bypass_read(ex_port.raddr2, regs[ex_port.raddr2],
                                        ex_port.we, ex_port.waddr, ex_port.wdata);

    // debug sees stored contents only, no forwarding
    assign dbg_port.rdata1 = (dbg_port.raddr1 == `ZERO_REG) ? '0 : regs[dbg_port.raddr1];
    assign dbg_port.rdata2 = (dbg_port.raddr2 == `ZERO_REG) ? '0 : regs[dbg_port.raddr2];

endmodule

`default_nettype wire

// ==== verilog/alu_exec.sv ====
`default_nettype none

`include "core_consts.svh"

module alu_exec (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  issue_i,
    input  rv_alu_pkg::alu_op_e   op_i,
    input  rv_alu_pkg::reg_addr_t rd_i,
    input  rv_alu_pkg::reg_addr_t rs1_i,
    input  rv_alu_pkg::reg_addr_t rs2_i,
    input  logic [`IMM_W-1:0]     imm_i,
    gpr_port_if.agent             rf,
    output logic                  wb_valid_o,
    output rv_alu_pkg::reg_addr_t wb_rd_o,
    output rv_alu_pkg::word_t     wb_data_o
);

    rv_alu_pkg::word_t     op_a;
    rv_alu_pkg::word_t     op_b;
    rv_alu_pkg::word_t     result;
    logic [`SHAMT_W-1:0]   shamt;

    logic                  valid_q;
    rv_alu_pkg::reg_addr_t rd_q;
    rv_alu_pkg::word_t     data_q;

    // operands come back combinationally, bypassed if the previous result targets them
    assign rf.raddr1 = rs1_i;
    assign rf.raddr2 = rs2_i;
    assign op_a      = rf.rdata1;
    assign op_b      = rf.rdata2;
    assign shamt     = op_b[`SHAMT_W-1:0];

    always_comb begin
        case (op_i)
            rv_alu_pkg::ALU_ADD: result = op_a + op_b;
            rv_alu_pkg::ALU_SUB: result = op_a - op_b;
            rv_alu_pkg::ALU_AND: result = op_a & op_b;
            rv_alu_pkg::ALU_OR:  result = op_a | op_b;
            rv_alu_pkg::ALU_XOR: result = op_a ^ op_b;
            rv_alu_pkg::ALU_SLL: result = op_a << shamt;
            rv_alu_pkg::ALU_SRL: result = op_a >> shamt;
            rv_alu_pkg::ALU_LUI: result = {imm_i, {(`XLEN-`IMM_W){1'b0}}};
            default:             result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_i;
        end
    end

    // result stage, qualified by valid_q
    always_ff @(posedge clk) begin
        if (issue_i) begin
            rd_q   <= rd_i;
            data_q <= result;
        end
    end

    // writeback happens one edge after the result is registered
    assign rf.we    = valid_q;
    assign rf.waddr = rd_q;
    assign rf.wdata = data_q;

    assign wb_valid_o = valid_q;
    assign wb_rd_o    = rd_q;
    assign wb_data_o  = data_q;

endmodule

`default_nettype wire

// ==== verilog/dbg_access.sv ====
`default_nettype none

module dbg_access (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  dbg_req_i,
    input  dbg_pkg::dbg_cmd_e     dbg_cmd_i,
    input  rv_alu_pkg::reg_addr_t dbg_addr_i,
    input  rv_alu_pkg::word_t     dbg_wdata_i,
    output logic                  dbg_ack_o,
    output rv_alu_pkg::word_t     dbg_rdata_o,
    gpr_port_if.agent             rf
);

    dbg_pkg::dbg_state_e   state_q;
    dbg_pkg::dbg_cmd_e     cmd_q;
    rv_alu_pkg::reg_addr_t addr_q;
    rv_alu_pkg::word_t     wdata_q;
    rv_alu_pkg::word_t     rdata_q;
    logic                  accept;

    assign accept = (state_q == dbg_pkg::DBG_IDLE) && dbg_req_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= dbg_pkg::DBG_IDLE;
            cmd_q   <= dbg_pkg::DBG_READ;
        end else begin
            case (state_q)
                dbg_pkg::DBG_IDLE: begin
                    if (dbg_req_i) begin
                        cmd_q   <= dbg_cmd_i;
                        state_q <= dbg_pkg::DBG_WAIT_GNT;
                    end
                end
                dbg_pkg::DBG_WAIT_GNT: begin
                    // reads finish here in one cycle, writes hold until granted
                    if ((cmd_q == dbg_pkg::DBG_READ) || rf.gnt) begin
                        state_q <= dbg_pkg::DBG_ACK;
                    end
                end
                dbg_pkg::DBG_ACK: begin
                    if (!dbg_req_i) begin
                        state_q <= dbg_pkg::DBG_RELEASE;
                    end
                end
                default: state_q <= dbg_pkg::DBG_IDLE;   // release
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= dbg_addr_i;
            wdata_q <= dbg_wdata_i;
        end
        if ((state_q == dbg_pkg::DBG_WAIT_GNT) && (cmd_q == dbg_pkg::DBG_READ)) begin
            rdata_q <= rf.rdata1;   // held through ack
        end
    end

    // one address serves both read and write
    assign rf.raddr1 = addr_q;
    assign rf.waddr  = addr_q;
    assign rf.wdata  = wdata_q;
    assign rf.we     = (state_q == dbg_pkg::DBG_WAIT_GNT) && (cmd_q == dbg_pkg::DBG_WRITE);

    assign dbg_ack_o   = (state_q == dbg_pkg::DBG_ACK);
    assign dbg_rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/core_regs_top.sv ====
`default_nettype none

`include "core_consts.svh"

module core_regs_top (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // instruction issue
    input  logic                  issue_i,
    input  rv_alu_pkg::alu_op_e   op_i,
    input  rv_alu_pkg::reg_addr_t rd_i,
    input  rv_alu_pkg::reg_addr_t rs1_i,
    input  rv_alu_pkg::reg_addr_t rs2_i,
    input  logic [`IMM_W-1:0]     imm_i,

    // debug host
    input  logic                  dbg_req_i,
    input  dbg_pkg::dbg_cmd_e     dbg_cmd_i,
    input  rv_alu_pkg::reg_addr_t dbg_addr_i,
    input  rv_alu_pkg::word_t     dbg_wdata_i,
    output logic                  dbg_ack_o,
    output rv_alu_pkg::word_t     dbg_rdata_o,

    // writeback observation
    output logic                  wb_valid_o,
    output rv_alu_pkg::reg_addr_t wb_rd_o,
    output rv_alu_pkg::word_t     wb_data_o
);

    gpr_port_if ex_port ();
    gpr_port_if dbg_port ();

    // debug needs a single read port
    assign dbg_port.raddr2 = `ZERO_REG;

    gpr_file u_gpr_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ex_port  (ex_port.rf),
        .dbg_port (dbg_port.rf)
    );

    alu_exec u_alu_exec (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .issue_i    (issue_i),
        .op_i       (op_i),
        .rd_i       (rd_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .imm_i      (imm_i),
        .rf         (ex_port.agent),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

    dbg_access u_dbg_access (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dbg_req_i   (dbg_req_i),
        .dbg_cmd_i   (dbg_cmd_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_wdata_i (dbg_wdata_i),
        .dbg_ack_o   (dbg_ack_o),
        .dbg_rdata_o (dbg_rdata_o),
        .rf          (dbg_port.agent)
    );

endmodule

`default_nettype wire

// ==== tb/tb_core_regs.sv ====
`default_nettype none

`include "core_consts.svh"

module tb_core_regs;

    localparam int ACK_TIMEOUT = 64;

    logic                  clk;
    logic                  rst_n_i;
    logic                  issue_i;
    rv_alu_pkg::alu_op_e   op_i;
    rv_alu_pkg::reg_addr_t rd_i;
    rv_alu_pkg::reg_addr_t rs1_i;
    rv_alu_pkg::reg_addr_t rs2_i;
    logic [`IMM_W-1:0]     imm_i;
    logic                  dbg_req_i;
    dbg_pkg::dbg_cmd_e     dbg_cmd_i;
    rv_alu_pkg::reg_addr_t dbg_addr_i;
    rv_alu_pkg::word_t     dbg_wdata_i;
    logic                  dbg_ack_o;
    rv_alu_pkg::word_t     dbg_rdata_o;
    logic                  wb_valid_o;
    rv_alu_pkg::reg_addr_t wb_rd_o;
    rv_alu_pkg::word_t     wb_data_o;

    rv_alu_pkg::word_t     model [0:`REG_NUM-1];   // register state in program order
    integer                seed;
    logic                  exp_valid;
    rv_alu_pkg::reg_addr_t exp_rd;
    rv_alu_pkg::word_t     exp_data;
    rv_alu_pkg::reg_addr_t last_rd;                // source of back-to-back dependencies
    rv_alu_pkg::word_t     rd_val;
    logic [31:0]           rnd;

    core_regs_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_word(input rv_alu_pkg::word_t got, input rv_alu_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_rd(input rv_alu_pkg::reg_addr_t got, input rv_alu_pkg::reg_addr_t exp,
                            input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got x%0d expected x%0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // expected result by opcode with shifts taking rs2[4:0] and lui filling the upper 20 bits
    function automatic rv_alu_pkg::word_t alu_ref(input rv_alu_pkg::alu_op_e op,
                                                  input rv_alu_pkg::word_t a,
                                                  input rv_alu_pkg::word_t b,
                                                  input logic [`IMM_W-1:0] imm);
        rv_alu_pkg::word_t res;
        case (op)
            rv_alu_pkg::ALU_ADD: res = a + b;
            rv_alu_pkg::ALU_SUB: res = a - b;
            rv_alu_pkg::ALU_AND: res = a & b;
            rv_alu_pkg::ALU_OR:  res = a | b;
            rv_alu_pkg::ALU_XOR: res = a ^ b;
            rv_alu_pkg::ALU_SLL: res = a << b[4:0];
            rv_alu_pkg::ALU_SRL: res = a >> b[4:0];
            default:             res = {imm, 12'h000};
        endcase
        return res;
    endfunction

    // one clock, then compare the writeback stage with what was issued last cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        check_flag(wb_valid_o, exp_valid, "wb_valid_o");
        if (exp_valid) begin
            check_rd(wb_rd_o, exp_rd, "wb_rd_o");
            check_word(wb_data_o, exp_data, "wb_data_o");
        end
        issue_i   = 1'b0;    // idle unless the caller issues again
        exp_valid = 1'b0;
    endtask

    task automatic drain();
        next_cycle();
        next_cycle();
    endtask

    task automatic drive_issue(input rv_alu_pkg::alu_op_e op, input rv_alu_pkg::reg_addr_t rd,
                               input rv_alu_pkg::reg_addr_t rs1, input rv_alu_pkg::reg_addr_t rs2,
                               input logic [`IMM_W-1:0] imm);
        issue_i   = 1'b1;
        op_i      = op;
        rd_i      = rd;
        rs1_i     = rs1;
        rs2_i     = rs2;
        imm_i     = imm;
        exp_valid = 1'b1;
        exp_rd    = rd;
        exp_data  = alu_ref(op, model[rs1], model[rs2], imm);
        if (rd != `ZERO_REG) begin
            model[rd] = exp_data;
        end
        last_rd = rd;
    endtask

    task automatic issue_random(input logic avoid_en, input rv_alu_pkg::reg_addr_t avoid);
        logic [31:0]           r;
        logic [31:0]           r_imm;
        rv_alu_pkg::reg_addr_t rd;
        rv_alu_pkg::reg_addr_t rs1;
        rv_alu_pkg::reg_addr_t rs2;
        r     = $random(seed);
        r_imm = $random(seed);
        rd    = r[7:3];
        if (avoid_en && (rd == avoid)) begin
            rd = rd + 5'd1;
        end
        rs1 = r[8] ? last_rd : r[13:9];     // about half depend on the previous result
        rs2 = r[14] ? last_rd : r[19:15];
        drive_issue(rv_alu_pkg::alu_op_e'(r[2:0]), rd, rs1, rs2, r_imm[`IMM_W-1:0]);
    endtask

    // full four-phase access while an optional burst keeps the execute stage writing
    task automatic run_dbg(input dbg_pkg::dbg_cmd_e cmd, input rv_alu_pkg::reg_addr_t addr,
                           input rv_alu_pkg::word_t wdata, input int burst,
                           output rv_alu_pkg::word_t rdata, output int cycles);
        int rel;
        rel         = 0;
        cycles      = 0;
        rdata       = '0;
        dbg_req_i   = 1'b1;
        dbg_cmd_i   = cmd;
        dbg_addr_i  = addr;
        dbg_wdata_i = wdata;
        while (!dbg_ack_o && (cycles < ACK_TIMEOUT)) begin
            if (cycles < burst) begin
                issue_random(1'b1, addr);
            end
            next_cycle();
            cycles++;
        end
        if (!dbg_ack_o) begin
            $display("ERROR at %0t: debug port gave no ack within %0d cycles", $time, ACK_TIMEOUT);
            stop_run();
        end else begin
            rdata = dbg_rdata_o;
            next_cycle();    // req still high
            check_flag(dbg_ack_o, 1'b1, "dbg_ack_o held");
            check_word(dbg_rdata_o, rdata, "dbg_rdata_o held");
            dbg_req_i = 1'b0;
            next_cycle();
            while (dbg_ack_o && (rel < ACK_TIMEOUT)) begin
                next_cycle();
                rel++;
            end
            if (dbg_ack_o) begin
                $display("ERROR at %0t: debug ack stayed high after req was dropped", $time);
                stop_run();
            end else begin
                next_cycle();    // release state, port idle again after this edge
            end
        end
    endtask

    task automatic dbg_read(input rv_alu_pkg::reg_addr_t addr, output rv_alu_pkg::word_t data);
        int cycles;
        run_dbg(dbg_pkg::DBG_READ, addr, '0, 0, data, cycles);
        if (cycles != 2) begin
            $display("MISMATCH at %0t: debug read acked after %0d cycles, expected 2",
                     $time, cycles);
            stop_run();
        end
    endtask

    task automatic dbg_write(input rv_alu_pkg::reg_addr_t addr, input rv_alu_pkg::word_t data,
                             input int burst);
        rv_alu_pkg::word_t unused_rd;
        int                cycles;
        run_dbg(dbg_pkg::DBG_WRITE, addr, data, burst, unused_rd, cycles);
        if (cycles < burst + 2) begin
            $display("MISMATCH at %0t: debug write acked after %0d cycles during a %0d cycle burst",
                     $time, cycles, burst);
            stop_run();
        end else if (addr != `ZERO_REG) begin
            model[addr] = data;    // committed by the time ack shows
        end
    endtask

    task automatic read_check(input rv_alu_pkg::reg_addr_t addr);
        rv_alu_pkg::word_t got;
        dbg_read(addr, got);
        check_word(got, model[addr], $sformatf("debug read x%0d", addr));
    endtask

    initial begin
        seed        = 66486;
        rst_n_i     = 1'b0;
        issue_i     = 1'b0;
        op_i        = rv_alu_pkg::ALU_ADD;
        rd_i        = '0;
        rs1_i       = '0;
        rs2_i       = '0;
        imm_i       = '0;
        dbg_req_i   = 1'b0;
        dbg_cmd_i   = dbg_pkg::DBG_READ;
        dbg_addr_i  = '0;
        dbg_wdata_i = '0;
        exp_valid   = 1'b0;
        exp_rd      = '0;
        exp_data    = '0;
        last_rd     = '0;
        for (int i = 0; i < `REG_NUM; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1 rst_n_i = 1'b1;

        for (int i = 0; i < `REG_NUM; i++) begin
            read_check(rv_alu_pkg::reg_addr_t'(i));    // all zero after reset
        end

        for (int n = 0; n < 200; n++) begin
            issue_random(1'b0, `ZERO_REG);
            next_cycle();
            if (($random(seed) & 7) == 0) begin
                next_cycle();    // occasional bubble
            end
        end
        drain();

        // x0 writes, lui and shifts by rs2[4:0] = 7
        dbg_write(`ZERO_REG, 32'hDEAD_BEEF, 0);
        read_check(`ZERO_REG);
        dbg_write(5'd1, 32'h8000_00F1, 0);
        dbg_write(5'd2, 32'h0000_0FE7, 0);
        drive_issue(rv_alu_pkg::ALU_LUI, `ZERO_REG, 5'd1, 5'd2, 20'hFFFFF);
        next_cycle();
        drive_issue(rv_alu_pkg::ALU_OR, 5'd3, `ZERO_REG, `ZERO_REG, '0);
        next_cycle();
        drive_issue(rv_alu_pkg::ALU_SLL, 5'd4, 5'd1, 5'd2, '0);
        next_cycle();
        drive_issue(rv_alu_pkg::ALU_SRL, 5'd5, 5'd1, 5'd2, '0);
        next_cycle();
        drive_issue(rv_alu_pkg::ALU_LUI, 5'd6, 5'd1, 5'd2, 20'hABCDE);
        next_cycle();
        drain();
        read_check(`ZERO_REG);
        dbg_read(5'd3, rd_val);
        check_word(rd_val, 32'h0000_0000, "or of x0 after lui to x0");
        dbg_read(5'd4, rd_val);
        check_word(rd_val, 32'h0000_7880, "sll by 7");
        dbg_read(5'd5, rd_val);
        check_word(rd_val, 32'h0100_0001, "srl by 7");
        dbg_read(5'd6, rd_val);
        check_word(rd_val, 32'hABCD_E000, "lui");

        for (int n = 0; n < 24; n++) begin
            rnd = $random(seed);
            dbg_write(rnd[4:0], $random(seed), 0);
            read_check(rnd[4:0]);
            read_check(rnd[9:5]);
        end

        // debug write stalls behind a 12 cycle instruction burst
        dbg_write(5'd9, 32'h5A5A_C3C3, 12);
        drain();
        read_check(5'd9);

        for (int i = 0; i < `REG_NUM; i++) begin
            read_check(rv_alu_pkg::reg_addr_t'(i));
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/rv_alu_pkg.sv
verilog/dbg_pkg.sv
verilog/gpr_port_if.sv
verilog/gpr_file.sv
verilog/alu_exec.sv
verilog/dbg_access.sv
verilog/core_regs_top.sv
tb/tb_core_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f vlog.f --top-module tb_core_regs -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_core_regs
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

echo "simulation passed"
exit 0
